// File: hdl/race_pkg.sv
// Drag race shared types
package race_pkg;

    // race time, seconds above milliseconds so a plain compare orders it
    typedef struct packed {
        logic [11:0] seconds;
        logic [9:0]  milliseconds;
    } race_time_t;

    // gear 0 to 3
    typedef logic [1:0] gear_t;

    // position units per millisecond
    typedef logic [4:0] speed_t;

    // position along the track
    typedef logic [31:0] pos_t;

    // one byte on the board-to-board link
    typedef struct packed {
        logic   spare;
        logic   ready;
        logic   start;
        speed_t d_pos;
    } link_pkt_t;

    typedef enum logic [1:0] {
        PH_MENU   = 2'd0,
        PH_LIGHTS = 2'd1,
        PH_RACE   = 2'd2,
        PH_RESULT = 2'd3
    } phase_t;

    // top speed reachable in each gear
    localparam speed_t GEAR_TOP_SPEED [4] = '{
        5'd8,
        5'd14,
        5'd20,
        5'd31
    };

endpackage

// File: hdl/race_control.sv
// Race phase control
module race_control #(
    parameter int unsigned TICKS_PER_MS    = 65000,
    parameter int unsigned FINISH_LINE_POS = 25000,
    parameter int unsigned LIGHT_SECONDS   = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_tick,
    input  logic                 confirm_tick,
    input  race_pkg::pos_t       pos,
    input  race_pkg::pos_t       rival_pos,
    input  race_pkg::race_time_t light_time,
    input  race_pkg::race_time_t p1_time,
    input  race_pkg::race_time_t p2_time,
    input  logic                 rival_start,
    input  logic                 rival_ready,
    output logic                 ms_tick,
    output race_pkg::phase_t     phase,
    output logic                 light_run,
    output logic                 p1_run,
    output logic                 p2_run,
    output logic                 restart,
    output logic                 race_enable,
    output logic                 local_start,
    output logic                 local_ready,
    output logic [1:0]           winner
);
    import race_pkg::*;

    localparam int CNT_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             lights_done;
    logic             p1_done;
    logic             p2_done;

    // ------------------------------
    // millisecond prescaler
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            ms_tick  <= 1'b0;
        end else if (tick_cnt == CNT_W'(TICKS_PER_MS - 1)) begin
            tick_cnt <= '0;
            ms_tick  <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            ms_tick  <= 1'b0;
        end
    end

    // status flags
    assign lights_done = (light_time.seconds == 12'(LIGHT_SECONDS));
    assign p1_done     = (pos >= pos_t'(FINISH_LINE_POS));
    assign p2_done     = (rival_pos >= pos_t'(FINISH_LINE_POS));

    // timers run only in their own phase
    assign light_run   = (phase == PH_LIGHTS) && !lights_done;
    assign p1_run      = (phase == PH_RACE) && !p1_done;
    assign p2_run      = (phase == PH_RACE) && !p2_done;
    assign race_enable = p1_run;

    // ------------------------------
    // phase machine
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_MENU;
            local_start <= 1'b0;
            local_ready <= 1'b0;
            restart     <= 1'b0;
            winner      <= 2'd0;
        end else begin
            restart <= 1'b0;
            case (phase)
                PH_MENU: begin
                    if (start_tick) begin
                        local_start <= 1'b1;
                    end
                    // both boards must have pressed start
                    if (local_start && rival_start) begin
                        phase <= PH_LIGHTS;
                    end
                end
                PH_LIGHTS: begin
                    if (lights_done) begin
                        phase <= PH_RACE;
                    end
                end
                PH_RACE: begin
                    if (p1_done && p2_done) begin
                        phase <= PH_RESULT;
                        if (p1_time < p2_time) begin
                            winner <= 2'd1;
                        end else if (p1_time > p2_time) begin
                            winner <= 2'd2;
                        end else begin
                            winner <= 2'd3;
                        end
                    end
                end
                PH_RESULT: begin
                    if (confirm_tick) begin
                        local_ready <= 1'b1;
                    end
                    // scoreboard confirmed on both sides, back to menu
                    if (local_ready && rival_ready) begin
                        restart     <= 1'b1;
                        local_start <= 1'b0;
                        local_ready <= 1'b0;
                        winner      <= 2'd0;
                        phase       <= PH_MENU;
                    end
                end
                default: begin
                    phase <= PH_MENU;
                end
            endcase
        end
    end

endmodule

// File: hdl/gear_and_velocity.sv
// Local car model
module gear_and_velocity (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ms_tick,
    input  logic             shift_tick,
    input  logic             throttle,
    input  logic             race_enable,
    input  logic             restart,
    output race_pkg::gear_t  gear,
    output race_pkg::speed_t speed,
    output race_pkg::pos_t   pos,
    output logic             shift_ready
);
    import race_pkg::*;

    speed_t top_speed;
    speed_t speed_next;

    assign top_speed = GEAR_TOP_SPEED[gear];

    // driver may shift once the gear is maxed out
    assign shift_ready = (speed == top_speed);

    // ------------------------------
    // speed step for one millisecond
    // ------------------------------
    always_comb begin
        speed_next = speed;
        if (throttle) begin
            if (speed < top_speed) begin
                speed_next = speed + 1'b1;
            end
        end else if (speed != '0) begin
            // coasting, lose one unit per ms
            speed_next = speed - 1'b1;
        end
    end

    // gear selection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gear <= '0;
        end else if (restart) begin
            gear <= '0;
        end else if (race_enable && shift_tick && (gear != 2'd3)) begin
            gear <= gear + 1'b1;
        end
    end

    // speed and position, advanced on the ms tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speed <= '0;
            pos   <= '0;
        end else if (restart) begin
            speed <= '0;
            pos   <= '0;
        end else if (race_enable && ms_tick) begin
            speed <= speed_next;
            pos   <= pos + pos_t'(speed_next);
        end
    end

endmodule

// File: hdl/race_timer.sv
// Seconds and milliseconds timer
module race_timer #(
    parameter int unsigned MS_PER_SEC = 1000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ms_tick,
    input  logic                 start,
    input  logic                 restart,
    output race_pkg::race_time_t time_out
);

    logic ms_wrap;

    // last millisecond of the second
    assign ms_wrap = (time_out.milliseconds == 10'(MS_PER_SEC - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            time_out <= '0;
        end else if (restart) begin
            time_out <= '0;
        end else if (start && ms_tick) begin
            if (ms_wrap) begin
                time_out.milliseconds <= '0;
                time_out.seconds      <= time_out.seconds + 1'b1;
            end else begin
                time_out.milliseconds <= time_out.milliseconds + 1'b1;
            end
        end
    end

endmodule

// File: hdl/link_exchange.sv
// Board to board link packets
module link_exchange (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ms_tick,
    input  logic                local_start,
    input  logic                local_ready,
    input  race_pkg::speed_t    speed,
    input  logic                tx_full,
    input  logic                rx_empty,
    input  race_pkg::link_pkt_t rx_data,
    output logic                tx_wr,
    output race_pkg::link_pkt_t tx_data,
    output logic                rx_rd,
    output logic                rival_start,
    output logic                rival_ready,
    output race_pkg::speed_t    rival_dpos,
    output logic                rival_dpos_valid
);

    // ------------------------------
    // transmit side
    // ------------------------------

    // speed already holds this ms displacement when tx_wr is high
    assign tx_data = '{
        spare: 1'b0,
        ready: local_ready,
        start: local_start,
        d_pos: speed
    };

    // one write per ms, dropped when the FIFO is full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_wr <= 1'b0;
        end else begin
            tx_wr <= ms_tick && !tx_full;
        end
    end

    // ------------------------------
    // receive side
    // ------------------------------

    // first-word-fall-through, pop as soon as data shows up
    assign rx_rd = !rx_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rival_start      <= 1'b0;
            rival_ready      <= 1'b0;
            rival_dpos_valid <= 1'b0;
        end else begin
            rival_dpos_valid <= !rx_empty;
            if (!rx_empty) begin
                rival_start <= rx_data.start;
                rival_ready <= rx_data.ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rx_empty) begin
            rival_dpos <= rx_data.d_pos;
        end
    end

endmodule

// File: hdl/rival_position.sv
// Rival position accumulator
module rival_position (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             restart,
    input  race_pkg::speed_t rival_dpos,
    input  logic             rival_dpos_valid,
    output race_pkg::pos_t   rival_pos
);
    import race_pkg::*;

    // sum of every displacement the rival reported
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rival_pos <= '0;
        end else if (restart) begin
            rival_pos <= '0;
        end else if (rival_dpos_valid) begin
            rival_pos <= rival_pos + pos_t'(rival_dpos);
        end
    end

endmodule

// File: hdl/race_top.sv
// Drag race core top level
module race_top #(
    parameter int unsigned FINISH_LINE_POS = 25000,
    parameter int unsigned TICKS_PER_MS    = 65000,
    parameter int unsigned MS_PER_SEC      = 1000,
    parameter int unsigned LIGHT_SECONDS   = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_tick,
    input  logic                 shift_tick,
    input  logic                 confirm_tick,
    input  logic                 throttle,
    input  logic                 tx_full,
    input  logic                 rx_empty,
    input  race_pkg::link_pkt_t  rx_data,
    output logic                 tx_wr,
    output race_pkg::link_pkt_t  tx_data,
    output logic                 rx_rd,
    output race_pkg::phase_t     phase,
    output race_pkg::gear_t      gear,
    output logic                 shift_ready,
    output logic [11:0]          light_seconds,
    output race_pkg::race_time_t p1_time,
    output race_pkg::race_time_t p2_time,
    output logic [1:0]           winner
);
    import race_pkg::*;

    // control to datapath
    logic ms_tick;
    logic restart;
    logic light_run;
    logic p1_run;
    logic p2_run;
    logic race_enable;
    logic local_start;
    logic local_ready;

    // link side
    logic   rival_start;
    logic   rival_ready;
    speed_t rival_dpos;
    logic   rival_dpos_valid;

    // car state
    speed_t     speed;
    pos_t       pos;
    pos_t       rival_pos;
    race_time_t light_time;

    assign light_seconds = light_time.seconds;

    race_control #(
        .TICKS_PER_MS    (TICKS_PER_MS),
        .FINISH_LINE_POS (FINISH_LINE_POS),
        .LIGHT_SECONDS   (LIGHT_SECONDS)
    ) u_race_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_tick   (start_tick),
        .confirm_tick (confirm_tick),
        .pos          (pos),
        .rival_pos    (rival_pos),
        .light_time   (light_time),
        .p1_time      (p1_time),
        .p2_time      (p2_time),
        .rival_start  (rival_start),
        .rival_ready  (rival_ready),
        .ms_tick      (ms_tick),
        .phase        (phase),
        .light_run    (light_run),
        .p1_run       (p1_run),
        .p2_run       (p2_run),
        .restart      (restart),
        .race_enable  (race_enable),
        .local_start  (local_start),
        .local_ready  (local_ready),
        .winner       (winner)
    );

    gear_and_velocity u_gear_and_velocity (
        .clk         (clk),
        .rst_n       (rst_n),
        .ms_tick     (ms_tick),
        .shift_tick  (shift_tick),
        .throttle    (throttle),
        .race_enable (race_enable),
        .restart     (restart),
        .gear        (gear),
        .speed       (speed),
        .pos         (pos),
        .shift_ready (shift_ready)
    );

    // ------------------------------
    // timers: start lights, local player, rival
    // ------------------------------
    race_timer #(.MS_PER_SEC(MS_PER_SEC)) u_light_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .ms_tick  (ms_tick),
        .start    (light_run),
        .restart  (restart),
        .time_out (light_time)
    );

    race_timer #(.MS_PER_SEC(MS_PER_SEC)) u_p1_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .ms_tick  (ms_tick),
        .start    (p1_run),
        .restart  (restart),
        .time_out (p1_time)
    );

    race_timer #(.MS_PER_SEC(MS_PER_SEC)) u_p2_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .ms_tick  (ms_tick),
        .start    (p2_run),
        .restart  (restart),
        .time_out (p2_time)
    );

    link_exchange u_link_exchange (
        .clk              (clk),
        .rst_n            (rst_n),
        .ms_tick          (ms_tick),
        .local_start      (local_start),
        .local_ready      (local_ready),
        .speed            (speed),
        .tx_full          (tx_full),
        .rx_empty         (rx_empty),
        .rx_data          (rx_data),
        .tx_wr            (tx_wr),
        .tx_data          (tx_data),
        .rx_rd            (rx_rd),
        .rival_start      (rival_start),
        .rival_ready      (rival_ready),
        .rival_dpos       (rival_dpos),
        .rival_dpos_valid (rival_dpos_valid)
    );

    rival_position u_rival_position (
        .clk              (clk),
        .rst_n            (rst_n),
        .restart          (restart),
        .rival_dpos       (rival_dpos),
        .rival_dpos_valid (rival_dpos_valid),
        .rival_pos        (rival_pos)
    );

endmodule

// File: include/race_tb_table.svh
// Drag race bench table
`ifndef RACE_TB_TABLE_SVH
`define RACE_TB_TABLE_SVH

// winner column value meaning compare the bench timers instead
localparam int WIN_FROM_TIMES = 7;
localparam int NUM_ROWS       = 16;

typedef struct packed {
    logic       start;
    logic       shift;
    logic       confirm;
    logic       throttle;
    logic       tx_full;
    logic       r_start;
    logic       r_ready;
    logic       r_rand;
    logic [4:0] r_dpos;
    logic [7:0] ms;
    phase_t     exp_phase;
    logic [1:0] exp_gear;
    logic       exp_sr;
    logic [2:0] exp_win;
} tb_row_t;

// columns: start shift confirm throttle tx_full | rival start ready random dpos |
//          ms | expected phase gear shift_ready winner
localparam tb_row_t race_rows [NUM_ROWS] = '{
    // first race, local start alone then the rival joins
    '{1, 0, 0, 0, 0, 0, 0, 0, 5'd0,  8'd3,  PH_MENU,   2'd0, 0, 3'd0},
    '{0, 0, 0, 0, 0, 1, 0, 0, 5'd0,  8'd3,  PH_LIGHTS, 2'd0, 0, 3'd0},
    '{0, 0, 0, 0, 0, 1, 0, 0, 5'd0,  8'd20, PH_RACE,   2'd0, 0, 3'd0},
    // climb through the gears
    '{0, 0, 0, 1, 0, 0, 0, 0, 5'd10, 8'd10, PH_RACE,   2'd0, 1, 3'd0},
    '{0, 1, 0, 1, 0, 0, 0, 0, 5'd10, 8'd8,  PH_RACE,   2'd1, 1, 3'd0},
    // tx FIFO full, packets dropped
    '{0, 1, 0, 1, 1, 0, 0, 0, 5'd10, 8'd5,  PH_RACE,   2'd2, 0, 3'd0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 5'd10, 8'd4,  PH_RACE,   2'd2, 0, 3'd0},
    '{0, 0, 0, 1, 0, 0, 0, 0, 5'd20, 8'd6,  PH_RACE,   2'd2, 1, 3'd0},
    '{0, 0, 0, 1, 0, 0, 0, 0, 5'd31, 8'd3,  PH_RESULT, 2'd2, 1, 3'd1},
    // scoreboard confirm, local first
    '{0, 0, 1, 0, 0, 0, 0, 0, 5'd0,  8'd3,  PH_RESULT, 2'd2, 1, 3'd1},
    '{0, 0, 0, 0, 0, 0, 1, 0, 5'd0,  8'd2,  PH_MENU,   2'd0, 0, 3'd0},
    // second race with random rival displacement
    '{1, 0, 0, 0, 0, 1, 0, 0, 5'd0,  8'd2,  PH_LIGHTS, 2'd0, 0, 3'd0},
    '{0, 0, 0, 0, 0, 1, 0, 0, 5'd0,  8'd20, PH_RACE,   2'd0, 0, 3'd0},
    '{0, 1, 0, 1, 0, 0, 0, 1, 5'd0,  8'd10, PH_RACE,   2'd1, 0, 3'd0},
    '{0, 1, 0, 1, 0, 0, 0, 1, 5'd0,  8'd22, PH_RESULT, 2'd2, 1, 3'd7},
    '{0, 0, 1, 0, 0, 0, 1, 0, 5'd0,  8'd3,  PH_MENU,   2'd0, 0, 3'd0}
};

`endif

// File: bench/race_tb.sv
// Drag race core testbench
module race_tb;
    import race_pkg::*;

    `include "race_tb_table.svh"

    localparam int FINISH_LINE_POS = 400;
    localparam int TICKS_PER_MS    = 4;
    localparam int MS_PER_SEC      = 10;
    localparam int LIGHT_SECONDS   = 2;

    logic       clk;
    logic       rst_n;
    logic       start_tick;
    logic       shift_tick;
    logic       confirm_tick;
    logic       throttle;
    logic       tx_full;
    logic       rx_empty;
    link_pkt_t  rx_data;
    logic       tx_wr;
    link_pkt_t  tx_data;
    logic       rx_rd;
    phase_t     phase;
    gear_t      gear;
    logic       shift_ready;
    logic [11:0] light_seconds;
    race_time_t p1_time;
    race_time_t p2_time;
    logic [1:0] winner;

    integer     seed = 32'h39b0_3a43;
    int         errors;
    int         cycles;
    int         cycle_limit;
    int         row_idx;
    int         sum_at_row;
    link_pkt_t  rx_q [$];
    tb_row_t    cur;
    phase_t     prev_phase;

    // reference model of both cars
    int exp_speed;
    int exp_gear;
    int exp_pos;
    int rival_sum;
    int sum_tx;
    int p1_ms;
    int p2_ms;
    int light_ms;
    logic exp_local_start;
    logic exp_local_ready;

    race_top #(
        .FINISH_LINE_POS (FINISH_LINE_POS),
        .TICKS_PER_MS    (TICKS_PER_MS),
        .MS_PER_SEC      (MS_PER_SEC),
        .LIGHT_SECONDS   (LIGHT_SECONDS)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_tick    (start_tick),
        .shift_tick    (shift_tick),
        .confirm_tick  (confirm_tick),
        .throttle      (throttle),
        .tx_full       (tx_full),
        .rx_empty      (rx_empty),
        .rx_data       (rx_data),
        .tx_wr         (tx_wr),
        .tx_data       (tx_data),
        .rx_rd         (rx_rd),
        .phase         (phase),
        .gear          (gear),
        .shift_ready   (shift_ready),
        .light_seconds (light_seconds),
        .p1_time       (p1_time),
        .p2_time       (p2_time),
        .winner        (winner)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit on rising edges
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles without finishing", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic int top_speed_of(input int g);
        case (g)
            0: return 8;
            1: return 14;
            2: return 20;
            default: return 31;
        endcase
    endfunction

    function automatic int table_ms_total();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += race_rows[i].ms;
        end
        return total;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int exp);
        errors++;
        $display("[ERROR] %0t row %0d: %s is %0d, expected %0d",
                 $time, row_idx, what, got, exp);
    endtask

    task automatic clear_model();
        exp_speed       = 0;
        exp_gear        = 0;
        exp_pos         = 0;
        rival_sum       = 0;
        p1_ms           = 0;
        p2_ms           = 0;
        light_ms        = 0;
        exp_local_start = 1'b0;
        exp_local_ready = 1'b0;
    endtask

    // advance one falling edge and update the rival FIFO
    task automatic step_cycle();
        @(negedge clk);
        start_tick   = 1'b0;
        shift_tick   = 1'b0;
        confirm_tick = 1'b0;
        if (rx_rd !== !rx_empty) begin
            report_mismatch("rx_rd", rx_rd, !rx_empty);
        end
        // word shown last cycle was popped at the rising edge
        if (rx_rd === 1'b1 && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
        end
        if (rx_q.size() > 0) begin
            rx_empty = 1'b0;
            rx_data  = rx_q[0];
        end else begin
            rx_empty = 1'b1;
            rx_data  = '0;
        end
    endtask

    // millisecond boundary as seen on the cycle of tx_wr
    task automatic ms_event();
        link_pkt_t pkt;
        int        dpos;
        if (prev_phase == PH_RESULT && phase == PH_MENU) begin
            clear_model();
        end
        prev_phase = phase;
        if (phase == PH_LIGHTS && light_ms < LIGHT_SECONDS * MS_PER_SEC) begin
            light_ms++;
        end
        if (phase == PH_RACE) begin
            if (exp_pos < FINISH_LINE_POS) begin
                if (cur.throttle) begin
                    if (exp_speed < top_speed_of(exp_gear)) begin
                        exp_speed++;
                    end
                end else if (exp_speed > 0) begin
                    exp_speed--;
                end
                exp_pos += exp_speed;
                p1_ms++;
            end
            if (rival_sum < FINISH_LINE_POS) begin
                p2_ms++;
            end
        end
        if (tx_wr !== !cur.tx_full) begin
            report_mismatch("tx_wr", tx_wr, !cur.tx_full);
        end
        if (tx_wr === 1'b1) begin
            if (tx_data.d_pos !== exp_speed) begin
                report_mismatch("d_pos", tx_data.d_pos, exp_speed);
            end
            if (tx_data.start !== exp_local_start) begin
                report_mismatch("sent start flag", tx_data.start, exp_local_start);
            end
            if (tx_data.ready !== exp_local_ready) begin
                report_mismatch("sent ready flag", tx_data.ready, exp_local_ready);
            end
            if (tx_data.spare !== 1'b0) begin
                report_mismatch("sent spare bit", tx_data.spare, 0);
            end
            sum_tx += tx_data.d_pos;
            dpos = cur.r_rand ? 16 + ($random(seed) & 15) : cur.r_dpos;
            pkt.spare = 1'b0;
            pkt.ready = cur.r_ready;
            pkt.start = cur.r_start;
            pkt.d_pos = 5'(dpos);
            rx_q.push_back(pkt);
            rival_sum += dpos;
        end
    endtask

    task automatic check_row();
        int exp_win;
        exp_win = (p1_ms < p2_ms) ? 1 : (p1_ms > p2_ms) ? 2 : 3;
        if (phase !== cur.exp_phase) report_mismatch("phase", phase, cur.exp_phase);
        if (gear !== cur.exp_gear) report_mismatch("gear", gear, cur.exp_gear);
        if (gear !== exp_gear) report_mismatch("gear vs model", gear, exp_gear);
        if (shift_ready !== cur.exp_sr) report_mismatch("shift_ready", shift_ready, cur.exp_sr);
        if (cur.exp_win != WIN_FROM_TIMES && winner !== cur.exp_win) begin
            report_mismatch("winner", winner, cur.exp_win);
        end
        if (phase == PH_RESULT) begin
            if (winner !== exp_win) report_mismatch("winner vs times", winner, exp_win);
            if (exp_pos < FINISH_LINE_POS) begin
                report_mismatch("local sum", exp_pos, FINISH_LINE_POS);
            end
            if (rival_sum < FINISH_LINE_POS) begin
                report_mismatch("rival sum", rival_sum, FINISH_LINE_POS);
            end
        end
        if (p1_time.seconds !== p1_ms / MS_PER_SEC) begin
            report_mismatch("p1 seconds", p1_time.seconds, p1_ms / MS_PER_SEC);
        end
        if (p1_time.milliseconds !== p1_ms % MS_PER_SEC) begin
            report_mismatch("p1 ms", p1_time.milliseconds, p1_ms % MS_PER_SEC);
        end
        if (p2_time.seconds !== p2_ms / MS_PER_SEC) begin
            report_mismatch("p2 seconds", p2_time.seconds, p2_ms / MS_PER_SEC);
        end
        if (p2_time.milliseconds !== p2_ms % MS_PER_SEC) begin
            report_mismatch("p2 ms", p2_time.milliseconds, p2_ms % MS_PER_SEC);
        end
        if (light_seconds !== light_ms / MS_PER_SEC) begin
            report_mismatch("light_seconds", light_seconds, light_ms / MS_PER_SEC);
        end
        // dropped packets never count
        if (cur.tx_full && sum_tx != sum_at_row) begin
            report_mismatch("sent sum", sum_tx, sum_at_row);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_n        = 1'b0;
        start_tick   = 1'b0;
        shift_tick   = 1'b0;
        confirm_tick = 1'b0;
        throttle     = 1'b0;
        tx_full      = 1'b0;
        rx_empty     = 1'b1;
        rx_data      = '0;
        errors       = 0;
        cycles       = 0;
        sum_tx       = 0;
        row_idx      = -1;
        cur          = '0;
        prev_phase   = PH_MENU;
        clear_model();
        cycle_limit = 2 * table_ms_total() * TICKS_PER_MS;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        step_cycle();

        // state right after reset
        if (phase !== PH_MENU) report_mismatch("phase", phase, PH_MENU);
        if (tx_wr !== 1'b0) report_mismatch("tx_wr", tx_wr, 0);
        if (rx_rd !== 1'b0) report_mismatch("rx_rd", rx_rd, 0);
        if (gear !== 2'd0) report_mismatch("gear", gear, 0);
        if (shift_ready !== 1'b0) report_mismatch("shift_ready", shift_ready, 0);
        if (light_seconds !== 12'd0) report_mismatch("light_seconds", light_seconds, 0);
        if (p1_time !== '0) report_mismatch("p1_time", p1_time, 0);
        if (p2_time !== '0) report_mismatch("p2_time", p2_time, 0);
        if (winner !== 2'd0) report_mismatch("winner", winner, 0);

        // line up with the first packet
        while (tx_wr !== 1'b1) begin
            step_cycle();
        end
        ms_event();

        for (int i = 0; i < NUM_ROWS; i++) begin
            row_idx    = i;
            cur        = race_rows[i];
            sum_at_row = sum_tx;
            throttle   = cur.throttle;
            tx_full    = cur.tx_full;
            start_tick   = cur.start;
            confirm_tick = cur.confirm;
            if (cur.start && phase == PH_MENU) begin
                exp_local_start = 1'b1;
            end
            if (cur.confirm && phase == PH_RESULT) begin
                exp_local_ready = 1'b1;
            end
            if (cur.shift) begin
                shift_tick = 1'b1;
                if (phase == PH_RACE && exp_pos < FINISH_LINE_POS && exp_gear < 3) begin
                    exp_gear++;
                end
            end
            for (int m = 0; m < cur.ms; m++) begin
                repeat (TICKS_PER_MS - 1) begin
                    step_cycle();
                    if (tx_wr !== 1'b0) report_mismatch("tx_wr between ticks", tx_wr, 0);
                end
                step_cycle();
                ms_event();
            end
            check_row();
        end

        $display("errors: %0d after %0d rows", errors, NUM_ROWS);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
hdl/race_pkg.sv
hdl/race_control.sv
hdl/gear_and_velocity.sv
hdl/race_timer.sv
hdl/link_exchange.sv
hdl/rival_position.sv
hdl/race_top.sv
bench/race_tb.sv
